//--- axi_mem_defs.svh
/* Bus widths, outstanding depth and memory size for the AXI3 slave memory
   Derived index and byte-offset widths */
`ifndef AXI_MEM_DEFS_SVH
`define AXI_MEM_DEFS_SVH

// ----------------------------------------
// AXI field widths
// ----------------------------------------
`define AXI_DATA_W      64      // Fixed data width
`define AXI_STRB_W      8       // One strobe per data byte
`define AXI_ADDR_W      32
`define AXI_ID_W        4
`define AXI_LEN_W       4       // AXI3 bursts of 1 to 16 beats

// ----------------------------------------
// Capacity
// ----------------------------------------
`define AXI_MO_DEPTH    8       // Outstanding requests per direction
`define AXI_MEM_WORDS   1024    // Power of two, index wraps

// Word index width and byte offset inside a beat
`define AXI_IDX_W       $clog2(`AXI_MEM_WORDS)
`define AXI_BYTE_OFS    $clog2(`AXI_STRB_W)

`endif

//--- axi_mem_pkg.sv
/* Shared types of the AXI3 slave memory
   Burst type, address request struct, data beat union */
`include "axi_mem_defs.svh"

package axi_mem_pkg;

    // ----------------------------------------
    // Burst type, AXI3 AxBURST encoding
    // ----------------------------------------
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    // ----------------------------------------
    // One AR or AW request, 42 bits
    // ----------------------------------------
    typedef struct packed {
        axi_burst_e             burst;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;   // Beats minus one
        logic [`AXI_ID_W-1:0]   id;
    } axi_req_t;

    // One data beat, seen as a word or as bytes
    typedef union packed {
        logic [`AXI_DATA_W-1:0]      word;
        logic [`AXI_STRB_W-1:0][7:0] bytes;  // Byte 0 is the lowest lane
    } axi_beat_u;

endpackage

//--- axi_req_fifo.sv
/* In-order FIFO for outstanding requests and response IDs
   Circular buffer, wrap-bit pointers, head visible combinationally */
module axi_req_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8     // Power of two
) (
    input  bit               ACLK,
    input  bit               ARESETn,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    output logic             full,
    input  logic             pop,
    output logic             empty,
    output logic [WIDTH-1:0] head
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W:0]   wptr;     // MSB is the wrap bit
    logic [PTR_W:0]   rptr;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // ----------------------------------------
    // Status from the pointers
    // ----------------------------------------
    assign empty = (wptr == rptr);
    assign full  = (wptr[PTR_W] != rptr[PTR_W]) &&
                   (wptr[PTR_W-1:0] == rptr[PTR_W-1:0]);

    assign head = mem[rptr[PTR_W-1:0]];   // Oldest entry

    // Storage
    always_ff @(posedge ACLK) begin
        if (do_push) begin
            mem[wptr[PTR_W-1:0]] <= push_data;
        end
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (do_push) begin
                wptr <= wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

endmodule

//--- axi_beat_tracker.sv
/* Beat counter and word address generator for one burst
   FIXED, INCR and WRAP address rules */
`include "axi_mem_defs.svh"

module axi_beat_tracker (
    input  bit                     ACLK,
    input  bit                     ARESETn,
    input  axi_mem_pkg::axi_req_t  req,
    input  logic                   beat,        // Beat handshake
    output logic                   last,
    output logic [`AXI_IDX_W-1:0]  word_addr
);

    import axi_mem_pkg::*;

    localparam int IDX_W = `AXI_IDX_W;
    localparam int LEN_W = `AXI_LEN_W;

    logic [LEN_W-1:0] count;        // Beats done in this burst
    logic [LEN_W-1:0] len_p1;
    logic [IDX_W-1:0] base_idx;
    logic [IDX_W-1:0] count_idx;
    logic [IDX_W-1:0] wrap_mask;
    logic [IDX_W-1:0] incr_idx;
    logic             wrap_ok;

    // ----------------------------------------
    // Beat counting
    // ----------------------------------------
    assign last = (count == req.len);

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            count <= '0;
        end else if (beat) begin
            count <= last ? '0 : count + 1'b1;
        end
    end

    // ----------------------------------------
    // Address rule
    // ----------------------------------------
    assign base_idx  = req.addr[`AXI_BYTE_OFS +: IDX_W];   // Word above byte offset
    assign count_idx = {{(IDX_W-LEN_W){1'b0}}, count};
    assign incr_idx  = base_idx + count_idx;

    // WRAP needs 2, 4, 8 or 16 beats
    assign len_p1    = req.len + 1'b1;
    assign wrap_ok   = (req.len != '0) && ((req.len & len_p1) == '0);
    assign wrap_mask = {{(IDX_W-LEN_W){1'b0}}, req.len};

    always_comb begin
        case (req.burst)
            INCR: word_addr = incr_idx;
            WRAP: begin
                if (wrap_ok) begin
                    // Low bits roll over, upper bits stay
                    word_addr = (base_idx & ~wrap_mask) | (incr_idx & wrap_mask);
                end else begin
                    word_addr = base_idx;
                end
            end
            default: word_addr = base_idx;     // FIXED and reserved
        endcase
    end

endmodule

//--- axi_mem_array.sv
/* Word memory of the slave
   Combinational read port, byte-strobed write port */
`include "axi_mem_defs.svh"

module axi_mem_array (
    input  bit                       ACLK,
    input  logic [`AXI_IDX_W-1:0]    rd_addr,
    output axi_mem_pkg::axi_beat_u   rd_data,
    input  logic                     wr_en,
    input  logic [`AXI_IDX_W-1:0]    wr_addr,
    input  logic [`AXI_STRB_W-1:0]   wr_strb,
    input  axi_mem_pkg::axi_beat_u   wr_data
);

    import axi_mem_pkg::*;

    axi_beat_u mem [`AXI_MEM_WORDS];

    // ----------------------------------------
    // Read, zero cycles
    // ----------------------------------------
    assign rd_data = mem[rd_addr];

    // ----------------------------------------
    // Write, enabled byte lanes only
    // ----------------------------------------
    always_ff @(posedge ACLK) begin
        if (wr_en) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_addr].bytes[i] <= wr_data.bytes[i];
                end
            end
        end
    end

endmodule

//--- axi_rd_engine.sv
/* Read data channel engine
   Walks the head read request and presents R beats */
`include "axi_mem_defs.svh"

module axi_rd_engine (
    input  bit                       ACLK,
    input  bit                       ARESETn,
    input  axi_mem_pkg::axi_req_t    req,         // Head of read FIFO
    input  logic                     req_valid,
    output logic                     req_pop,
    input  logic                     rd_hold,
    input  logic                     rready,
    output logic                     rvalid,
    output logic [`AXI_ID_W-1:0]     rid,
    output logic                     rlast,
    output logic [`AXI_IDX_W-1:0]    mem_addr,
    input  axi_mem_pkg::axi_beat_u   mem_data,
    output logic [`AXI_DATA_W-1:0]   rdata
);

    logic beat;
    logic last;

    // ----------------------------------------
    // R handshake
    // ----------------------------------------
    assign rvalid  = req_valid && !rd_hold;
    assign beat    = rvalid && rready;
    assign req_pop = beat && last;          // Burst done, next request

    assign rid   = req.id;
    assign rlast = rvalid && last;

    // Beat position and word address
    axi_beat_tracker u_tracker (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .req       (req),
        .beat      (beat),
        .last      (last),
        .word_addr (mem_addr)
    );

    assign rdata = mem_data.word;           // Current beat word

endmodule

//--- axi_wr_engine.sv
/* Write data channel engine
   Strobed memory writes, response ID queue, B channel */
`include "axi_mem_defs.svh"

module axi_wr_engine (
    input  bit                       ACLK,
    input  bit                       ARESETn,
    input  axi_mem_pkg::axi_req_t    req,         // Head of write FIFO
    input  logic                     req_valid,
    output logic                     req_pop,
    input  logic                     wr_hold,
    input  logic                     br_hold,
    input  logic                     wvalid,
    output logic                     wready,
    input  logic                     wlast,
    output logic                     mem_wr_en,
    output logic [`AXI_IDX_W-1:0]    mem_wr_addr,
    input  logic                     bready,
    output logic                     bvalid,
    output logic [`AXI_ID_W-1:0]     bid
);

    logic beat;
    logic burst_end;
    logic resp_full;
    logic resp_empty;
    logic resp_pop;

    // ----------------------------------------
    // W channel
    // ----------------------------------------
    // Needs an address and room for the response
    assign wready    = req_valid && !resp_full && !wr_hold;
    assign beat      = wvalid && wready;
    assign burst_end = beat && wlast;
    assign req_pop   = burst_end;

    assign mem_wr_en = beat;    // Write at the handshake edge

    // Count clears inside the tracker on its own last beat
    axi_beat_tracker u_tracker (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .req       (req),
        .beat      (beat),
        .last      (),
        .word_addr (mem_wr_addr)
    );

    // ----------------------------------------
    // B channel
    // ----------------------------------------
    assign bvalid   = !resp_empty && !br_hold;
    assign resp_pop = bvalid && bready;

    // IDs of bursts whose data is complete
    axi_req_fifo #(
        .WIDTH (`AXI_ID_W),
        .DEPTH (`AXI_MO_DEPTH)
    ) u_resp_fifo (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .push      (burst_end),
        .push_data (req.id),
        .full      (resp_full),
        .pop       (resp_pop),
        .empty     (resp_empty),
        .head      (bid)
    );

endmodule

//--- axi_mem_slave.sv
/* AXI3 slave memory, top level
   Request FIFOs, read and write engines, word memory */
`include "axi_mem_defs.svh"

module axi_mem_slave (
    input  bit                       ACLK,
    input  bit                       ARESETn,

    input  logic                     rd_hold,     // Stall R
    input  logic                     wr_hold,     // Stall W
    input  logic                     br_hold,     // Stall B

    // Read address
    input  logic                     arvalid,
    output logic                     arready,
    input  logic [`AXI_ID_W-1:0]     arid,
    input  logic [`AXI_ADDR_W-1:0]   araddr,
    input  logic [`AXI_LEN_W-1:0]    arlen,
    input  logic [1:0]               arburst,

    // Read data
    output logic                     rvalid,
    input  logic                     rready,
    output logic [`AXI_ID_W-1:0]     rid,
    output logic [`AXI_DATA_W-1:0]   rdata,
    output logic                     rlast,
    output logic [1:0]               rresp,

    // Write address
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`AXI_ID_W-1:0]     awid,
    input  logic [`AXI_ADDR_W-1:0]   awaddr,
    input  logic [`AXI_LEN_W-1:0]    awlen,
    input  logic [1:0]               awburst,

    // Write data
    input  logic                     wvalid,
    output logic                     wready,
    input  logic [`AXI_STRB_W-1:0]   wstrb,
    input  logic [`AXI_DATA_W-1:0]   wdata,
    input  logic                     wlast,

    // Write response
    output logic                     bvalid,
    input  logic                     bready,
    output logic [`AXI_ID_W-1:0]     bid,
    output logic [1:0]               bresp
);

    import axi_mem_pkg::*;

    axi_req_t                  ar_req;
    axi_req_t                  aw_req;
    axi_req_t                  rd_head;
    axi_req_t                  wr_head;
    logic                      rd_full;
    logic                      rd_empty;
    logic                      rd_pop;
    logic                      wr_full;
    logic                      wr_empty;
    logic                      wr_pop;
    logic [`AXI_IDX_W-1:0]     rd_addr;
    axi_beat_u                 rd_beat;
    logic                      mem_wr_en;
    logic [`AXI_IDX_W-1:0]     mem_wr_addr;
    axi_beat_u                 wr_beat;

    // ----------------------------------------
    // Address channels into the FIFOs
    // ----------------------------------------
    assign ar_req = '{burst: axi_burst_e'(arburst), addr: araddr, len: arlen, id: arid};
    assign aw_req = '{burst: axi_burst_e'(awburst), addr: awaddr, len: awlen, id: awid};

    assign arready = !rd_full;
    assign awready = !wr_full;

    axi_req_fifo #(
        .WIDTH ($bits(axi_req_t)),
        .DEPTH (`AXI_MO_DEPTH)
    ) u_rd_fifo (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .push      (arvalid && arready),
        .push_data (ar_req),
        .full      (rd_full),
        .pop       (rd_pop),
        .empty     (rd_empty),
        .head      (rd_head)
    );

    axi_req_fifo #(
        .WIDTH ($bits(axi_req_t)),
        .DEPTH (`AXI_MO_DEPTH)
    ) u_wr_fifo (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .push      (awvalid && awready),
        .push_data (aw_req),
        .full      (wr_full),
        .pop       (wr_pop),
        .empty     (wr_empty),
        .head      (wr_head)
    );

    // ----------------------------------------
    // Engines and memory
    // ----------------------------------------
    axi_rd_engine u_rd_engine (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .req       (rd_head),
        .req_valid (!rd_empty),
        .req_pop   (rd_pop),
        .rd_hold   (rd_hold),
        .rready    (rready),
        .rvalid    (rvalid),
        .rid       (rid),
        .rlast     (rlast),
        .mem_addr  (rd_addr),
        .mem_data  (rd_beat),
        .rdata     (rdata)
    );

    axi_wr_engine u_wr_engine (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .req         (wr_head),
        .req_valid   (!wr_empty),
        .req_pop     (wr_pop),
        .wr_hold     (wr_hold),
        .br_hold     (br_hold),
        .wvalid      (wvalid),
        .wready      (wready),
        .wlast       (wlast),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .bready      (bready),
        .bvalid      (bvalid),
        .bid         (bid)
    );

    assign wr_beat.word = wdata;

    axi_mem_array u_mem (
        .ACLK    (ACLK),
        .rd_addr (rd_addr),
        .rd_data (rd_beat),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_strb (wstrb),
        .wr_data (wr_beat)
    );

    assign rresp = 2'b00;   // OKAY
    assign bresp = 2'b00;   // OKAY

endmodule

//--- tb_axi_mem_ref.svh
/* Reference model for the AXI3 slave memory testbench
   Byte memory with known flags, burst address rule, expected R and B queues */
`ifndef TB_AXI_MEM_REF_SVH
`define TB_AXI_MEM_REF_SVH

// ----------------------------------------
// Byte memory, known only after a write
// ----------------------------------------
logic [7:0] ref_bytes [`AXI_MEM_WORDS*8];
bit         ref_known [`AXI_MEM_WORDS*8];

// Expected R beats and B IDs, in issue order
logic [63:0] exp_rdata[$];
logic [63:0] exp_rmask[$];
bit          exp_rlast[$];
logic [3:0]  exp_rid[$];
logic [3:0]  exp_bid[$];

// Word index of one beat, AXI3 burst rule
function automatic int word_index(logic [31:0] addr, logic [3:0] len,
                                  logic [1:0] burst, int beat);
    int base;
    int n;
    base = int'(addr >> 3) % `AXI_MEM_WORDS;
    n = int'(len) + 1;
    if (burst == 2'b01) begin
        return (base + beat) % `AXI_MEM_WORDS;
    end
    if (burst == 2'b10 && (n == 2 || n == 4 || n == 8 || n == 16)) begin
        return (base & ~(n - 1)) | ((base + beat) & (n - 1)); // Roll over in the block
    end
    return base;   // FIXED, and WRAP of other lengths
endfunction

function automatic void model_write(int idx, logic [7:0] strb, logic [63:0] data);
    for (int b = 0; b < 8; b++) begin
        if (strb[b]) begin
            ref_bytes[idx*8+b] = data[8*b +: 8];
            ref_known[idx*8+b] = 1'b1;
        end
    end
endfunction

function automatic logic [63:0] model_data(int idx);
    logic [63:0] w;
    w = '0;
    for (int b = 0; b < 8; b++) begin
        if (ref_known[idx*8+b]) w[8*b +: 8] = ref_bytes[idx*8+b];
    end
    return w;
endfunction

// Only bytes written so far are compared
function automatic logic [63:0] model_mask(int idx);
    logic [63:0] m;
    m = '0;
    for (int b = 0; b < 8; b++) begin
        if (ref_known[idx*8+b]) m[8*b +: 8] = 8'hff;
    end
    return m;
endfunction

`endif

//--- tb_axi_mem_slave.sv
/* Testbench for the AXI3 slave memory
   Clock, reset, random bursts, R and B monitor, timeout, summary */
`include "axi_mem_defs.svh"

module tb_axi_mem_slave;

    // 4 x (88 transactions x 24) + 500
    localparam int LIMIT = 4 * (88 * (16 + 8)) + 500;

    bit          ACLK;
    bit          ARESETn;
    logic        rd_hold, wr_hold, br_hold;
    logic        arvalid, awvalid, wvalid, wlast, rready, bready;
    logic        arready, awready, wready, rvalid, rlast, bvalid;
    logic [3:0]  arid, awid, rid, bid, arlen, awlen;
    logic [31:0] araddr, awaddr;
    logic [1:0]  arburst, awburst, rresp, bresp;
    logic [7:0]  wstrb;
    logic [63:0] wdata, rdata;
    int          errors, checks, tests_run, tests_failed, cycles, err_mark;
    bit          rand_ready, rand_hold;
    logic [31:0] wr_addrs[$];
    logic [3:0]  wr_lens[$];

    `include "tb_axi_mem_ref.svh"

    axi_mem_slave u_dut (.*);

    always #10 ACLK = ~ACLK;

    function automatic int unsigned rnd(int unsigned n);
        return $urandom % n;
    endfunction

    task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // ----------------------------------------
    // Bus drivers
    // ----------------------------------------
    task automatic write_burst(logic [3:0] id, logic [31:0] addr, logic [3:0] len,
                               logic [1:0] burst);
        @(negedge ACLK);
        {awvalid, awid, awaddr, awlen, awburst} = {1'b1, id, addr, len, burst};
        do @(posedge ACLK); while (!awready);
        exp_bid.push_back(id);
        for (int i = 0; i <= int'(len); i++) begin
            @(negedge ACLK);
            awvalid = 1'b0;
            if (rnd(4) == 0) begin
                wvalid = 1'b0;  // Idle gap
                @(negedge ACLK);
            end
            wvalid = 1'b1;
            wdata  = {$urandom, $urandom};
            wstrb  = 8'(rnd(256));
            wlast  = (i == int'(len));
            do @(posedge ACLK); while (!wready);
            model_write(word_index(addr, len, burst, i), wstrb, wdata);
        end
        @(negedge ACLK);
        wvalid = 1'b0;
        wlast  = 1'b0;
    endtask

    task automatic read_burst(logic [3:0] id, logic [31:0] addr, logic [3:0] len,
                              logic [1:0] burst);
        int idx;
        @(negedge ACLK);
        {arvalid, arid, araddr, arlen, arburst} = {1'b1, id, addr, len, burst};
        do @(posedge ACLK); while (!arready);
        for (int i = 0; i <= int'(len); i++) begin
            idx = word_index(addr, len, burst, i);
            exp_rdata.push_back(model_data(idx));
            exp_rmask.push_back(model_mask(idx));
            exp_rlast.push_back(i == int'(len));
            exp_rid.push_back(id);
        end
        @(negedge ACLK);
        arvalid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_rid.size() != 0 || exp_bid.size() != 0) @(negedge ACLK);
    endtask

    task automatic report_test(string name);
        tests_run++;
        if (errors != err_mark) tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (errors == err_mark) ? "ok" : "failed");
        err_mark = errors;
    endtask

    // Random ready and hold levels
    always @(negedge ACLK) begin
        if (rand_ready) begin
            rready = 1'(rnd(2));
            bready = 1'(rnd(2));
        end
        if (rand_hold) begin
            rd_hold = (rnd(6) == 0);
            wr_hold = (rnd(6) == 0);
            br_hold = (rnd(6) == 0);
        end
    end

    // ----------------------------------------
    // R and B monitor
    // ----------------------------------------
    always @(posedge ACLK) begin
        if (ARESETn) begin
            assert (!(rvalid && rd_hold) && !(bvalid && br_hold) && !(wready && wr_hold))
            else begin
                $display("t=%0t a valid or ready was high while its hold was high", $time);
                errors++;
            end
            if (rvalid && rready) begin
                assert (exp_rid.size() != 0) else begin
                    $display("t=%0t R beat arrived with no read outstanding", $time);
                    errors++;
                end
                if (exp_rid.size() != 0) begin
                    check_value("rdata", exp_rdata[0] & exp_rmask[0], rdata & exp_rmask[0]);
                    check_value("rlast", 64'(exp_rlast[0]), 64'(rlast));
                    check_value("rid", 64'(exp_rid[0]), 64'(rid));
                    check_value("rresp", 64'd0, 64'(rresp));
                    void'(exp_rdata.pop_front());
                    void'(exp_rmask.pop_front());
                    void'(exp_rlast.pop_front());
                    void'(exp_rid.pop_front());
                end
            end
            if (bvalid && bready) begin
                assert (exp_bid.size() != 0) else begin
                    $display("t=%0t B response arrived with no write outstanding", $time);
                    errors++;
                end
                if (exp_bid.size() != 0) begin
                    check_value("bid", 64'(exp_bid.pop_front()), 64'(bid));
                    check_value("bresp", 64'd0, 64'(bresp));
                end
            end
        end
    end

    // Run limit
    always @(posedge ACLK) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        logic [1:0] bt;
        logic [3:0] len;
        void'($urandom(77));
        {rd_hold, wr_hold, br_hold, arvalid, awvalid, wvalid, wlast} = '0;
        {arid, awid, arlen, awlen, araddr, awaddr, arburst, awburst} = '0;
        {wstrb, wdata} = '0;
        rready = 1'b1;
        bready = 1'b1;
        ARESETn = 1'b0;
        repeat (8) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;

        // Test 1 reset state
        @(negedge ACLK);
        check_value("arready", 64'd1, 64'(arready));
        check_value("awready", 64'd1, 64'(awready));
        check_value("rvalid", 64'd0, 64'(rvalid));
        check_value("wready", 64'd0, 64'(wready));
        check_value("bvalid", 64'd0, 64'(bvalid));
        report_test("reset state");

        // Test 2 strobed INCR writes, then reads of the same bursts
        for (int i = 0; i < 12; i++) begin
            wr_addrs.push_back($urandom);
            wr_lens.push_back(4'(rnd(16)));
            write_burst(4'(rnd(16)), wr_addrs[i], wr_lens[i], 2'b01);
        end
        wait_drain();
        for (int i = 0; i < 12; i++) read_burst(4'(rnd(16)), wr_addrs[i], wr_lens[i], 2'b01);
        wait_drain();
        report_test("strobed INCR write and read-back");

        // Test 3 FIXED and WRAP, read back over the aligned 16-word block
        wr_addrs.delete();
        for (int i = 0; i < 12; i++) begin
            if (i % 2 == 0) begin
                bt  = 2'b00;
                len = 4'(rnd(16));
                wr_addrs.push_back($urandom);
            end else begin
                bt = 2'b10;
                if (i % 4 == 1) begin
                    len = 4'((2 << rnd(4)) - 1);    // 2 to 16 beats
                end else begin
                    len = 4'(2 * rnd(7) + 2);       // Odd beat count, acts as FIXED
                end
                wr_addrs.push_back($urandom | 32'h8);   // Odd word start, rolls over
            end
            write_burst(4'(rnd(16)), wr_addrs[i], len, bt);
        end
        wait_drain();
        for (int i = 0; i < 12; i++) read_burst(4'(i), wr_addrs[i] & ~32'h7f, 4'd15, 2'b01);
        wait_drain();
        report_test("FIXED and WRAP addressing");

        // Test 4 outstanding reads with R stalled
        rready = 1'b0;
        for (int i = 0; i < `AXI_MO_DEPTH; i++) begin
            read_burst(4'(rnd(16)), $urandom, 4'(rnd(16)), 2'b01);
        end
        check_value("arready", 64'd0, 64'(arready));
        rready = 1'b1;
        wait_drain();
        report_test("outstanding ordered reads");

        // Test 5 random ready and hold levels
        rand_ready = 1'b1;
        rand_hold  = 1'b1;
        wr_addrs.delete();
        wr_lens.delete();
        for (int i = 0; i < 16; i++) begin
            wr_addrs.push_back($urandom);
            wr_lens.push_back(4'(rnd(16)));
            write_burst(4'(rnd(16)), wr_addrs[i], wr_lens[i], 2'(rnd(3)));
        end
        wait_drain();
        for (int i = 0; i < 16; i++) read_burst(4'(rnd(16)), wr_addrs[i], wr_lens[i], 2'b01);
        wait_drain();
        rand_ready = 1'b0;
        rand_hold  = 1'b0;
        report_test("back-pressure and holds");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
axi_mem_pkg.sv
axi_req_fifo.sv
axi_beat_tracker.sv
axi_mem_array.sv
axi_rd_engine.sv
axi_wr_engine.sv
axi_mem_slave.sv
tb_axi_mem_slave.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_mem_slave
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
FILELIST  ?= sources.f

.PHONY: sim clean

# Build, run, then look for the pass line
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
